// File: logic/mipsIsaPkg.sv
// MIPS32 major opcodes and function codes for the multiply, count and HI/LO instructions
package mipsIsaPkg;

    // major opcodes
    localparam logic [5:0] OpSpecial  = 6'b000000;
    localparam logic [5:0] OpSpecial2 = 6'b011100;

    // function field under SPECIAL
    localparam logic [5:0] FuncMfhi   = 6'b010000; // HI to rd
    localparam logic [5:0] FuncMthi   = 6'b010001; // rs to HI
    localparam logic [5:0] FuncMflo   = 6'b010010; // LO to rd
    localparam logic [5:0] FuncMtlo   = 6'b010011; // rs to LO
    localparam logic [5:0] FuncMult   = 6'b011000; // signed
    localparam logic [5:0] FuncMultu  = 6'b011001; // unsigned

    // function field under SPECIAL2
    localparam logic [5:0] FuncMadd   = 6'b000000; // HI/LO += signed product
    localparam logic [5:0] FuncMaddu  = 6'b000001; // HI/LO += unsigned product
    localparam logic [5:0] FuncMul    = 6'b000010; // low word only, HI/LO kept
    localparam logic [5:0] FuncMsub   = 6'b000100; // HI/LO -= signed product
    localparam logic [5:0] FuncMsubu  = 6'b000101; // HI/LO -= unsigned product
    localparam logic [5:0] FuncClz    = 6'b100000; // count leading zeros
    localparam logic [5:0] FuncClo    = 6'b100001; // count leading ones

endpackage

// File: logic/exMultPkg.sv
// datapath widths and flag bit positions of the execute multiply block
package exMultPkg;

    // operand word and full product
    localparam int WordWidth = 32;
    localparam int ProdWidth = 64;

    // flags vector layout
    localparam int FlagWidth = 4;
    localparam int FlagC     = 0; // carry, result bit 32
    localparam int FlagZ     = 1; // low word all zero
    localparam int FlagO     = 2; // overflow, same source as carry
    localparam int FlagN     = 3; // sign of low word

endpackage

// File: logic/exOpIf.sv
// interface for one issued operation, shared by the execute multiply blocks
interface exOpIf
    import exMultPkg::*;
();

    logic                 valid;  // one-cycle issue strobe
    logic [WordWidth-1:0] a;
    logic [WordWidth-1:0] b;
    logic                 selB;   // low means multiply by 1
    logic [5:0]           opCode;
    logic [5:0]           func;

    modport sink
    (
        input valid,
        input a,
        input b,
        input selB,
        input opCode,
        input func
    );

endinterface

// File: logic/exMultCount.sv
// leading zero/one counter, operand A passthrough and operand B select
module exMultCount
    import exMultPkg::*;
    import mipsIsaPkg::*;
(
    exOpIf.sink                  op,
    output logic [WordWidth-1:0] mB,
    output logic [ProdWidth-1:0] countOut
);

    // 0..WordWidth needs one bit above the index width
    localparam int CountWidth = $clog2(WordWidth) + 1;

    logic [CountWidth-1:0] zeroCount;
    logic [CountWidth-1:0] oneCount;

    function automatic logic [CountWidth-1:0] leadZeros(input logic [WordWidth-1:0] word);
        logic [CountWidth-1:0] count;
        logic                  seenOne;
        count   = '0;
        seenOne = 1'b0;
        for (int i = WordWidth - 1; i >= 0; i--)
        begin
            seenOne = seenOne | word[i];
            if (!seenOne)
            begin
                count = count + 1'b1;
            end
        end
        return count;
    endfunction

    always_comb
    begin
        mB = op.selB ? op.b : WordWidth'(1); // else multiply by 1
    end

    always_comb
    begin
        zeroCount = leadZeros(op.a);
        oneCount  = leadZeros(~op.a);     // leading ones are leading zeros of ~a
    end

    always_comb
    begin
        countOut = ProdWidth'(op.a);      // passthrough, zero-extended
        if (op.opCode == OpSpecial2)
        begin
            case (op.func)
                FuncClz: countOut = ProdWidth'(zeroCount);
                FuncClo: countOut = ProdWidth'(oneCount);
                default: countOut = ProdWidth'(op.a);
            endcase
        end
    end

endmodule

// File: logic/exHiLoUnit.sv
// two-stage multiplier with HI/LO registers, accumulate and move operations
module exHiLoUnit
    import exMultPkg::*;
    import mipsIsaPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    exOpIf.sink                  op,
    input  logic [WordWidth-1:0] mB,
    output logic                 stage2Valid,
    output logic                 ownsResult,
    output logic [ProdWidth-1:0] hiLoResult
);

    // decoded issue
    logic isLoad, isAdd, isSub, isMul;
    logic isMthi, isMtlo, isMfhi, isMflo;
    logic isSigned, owns;

    logic signed [WordWidth:0]   aExt;
    logic signed [WordWidth:0]   bExt;
    logic signed [WordWidth*2+1:0] prodWide;

    // stage 1
    logic                 s1Valid, s1Owns;
    logic                 s1Load, s1Add, s1Sub, s1Mul;
    logic                 s1Mthi, s1Mtlo, s1Mfhi, s1Mflo;
    logic [ProdWidth-1:0] s1Prod;
    logic [WordWidth-1:0] s1A;

    // HI/LO state
    logic [ProdWidth-1:0] hiLo;
    logic [ProdWidth-1:0] hiLoNext;
    logic [ProdWidth-1:0] resultNext;

    always_comb
    begin
        isLoad   = 1'b0;
        isAdd    = 1'b0;
        isSub    = 1'b0;
        isMul    = 1'b0;
        isMthi   = 1'b0;
        isMtlo   = 1'b0;
        isMfhi   = 1'b0;
        isMflo   = 1'b0;
        isSigned = 1'b0;
        if (op.valid && op.opCode == OpSpecial)
        begin
            case (op.func)
                FuncMult:  {isLoad, isSigned} = 2'b11;
                FuncMultu: isLoad = 1'b1;
                FuncMthi:  isMthi = 1'b1;
                FuncMtlo:  isMtlo = 1'b1;
                FuncMfhi:  isMfhi = 1'b1;
                FuncMflo:  isMflo = 1'b1;
                default:   isLoad = 1'b0;
            endcase
        end
        else if (op.valid && op.opCode == OpSpecial2)
        begin
            case (op.func)
                FuncMul:   {isMul, isSigned} = 2'b11;
                FuncMadd:  {isAdd, isSigned} = 2'b11;
                FuncMaddu: isAdd = 1'b1;
                FuncMsub:  {isSub, isSigned} = 2'b11;
                FuncMsubu: isSub = 1'b1;
                default:   isMul = 1'b0; // CLZ/CLO belong to the count path
            endcase
        end
        owns = isLoad | isAdd | isSub | isMul | isMthi | isMtlo | isMfhi | isMflo;
    end

    // one extra bit makes a single signed multiplier cover both signednesses
    always_comb
    begin
        aExt     = {isSigned & op.a[WordWidth-1], op.a};
        bExt     = {isSigned & mB[WordWidth-1], mB};
        prodWide = aExt * bExt;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            s1Valid <= 1'b0;
            s1Owns  <= 1'b0;
            s1Load  <= 1'b0;
            s1Add   <= 1'b0;
            s1Sub   <= 1'b0;
            s1Mul   <= 1'b0;
            s1Mthi  <= 1'b0;
            s1Mtlo  <= 1'b0;
            s1Mfhi  <= 1'b0;
            s1Mflo  <= 1'b0;
        end
        else
        begin
            s1Valid <= op.valid;
            s1Owns  <= owns;
            s1Load  <= isLoad;
            s1Add   <= isAdd;
            s1Sub   <= isSub;
            s1Mul   <= isMul;
            s1Mthi  <= isMthi;
            s1Mtlo  <= isMtlo;
            s1Mfhi  <= isMfhi;
            s1Mflo  <= isMflo;
        end
    end

    always_ff @(posedge clk)
    begin
        s1Prod <= prodWide[ProdWidth-1:0];
        s1A    <= op.a;
    end

    // stage 2 reads HI/LO as left by the op just ahead
    always_comb
    begin
        hiLoNext = hiLo;
        if (s1Load)
            hiLoNext = s1Prod;
        else if (s1Add)
            hiLoNext = hiLo + s1Prod;
        else if (s1Sub)
            hiLoNext = hiLo - s1Prod;
        else if (s1Mthi)
            hiLoNext = {s1A, hiLo[WordWidth-1:0]};
        else if (s1Mtlo)
            hiLoNext = {hiLo[ProdWidth-1:WordWidth], s1A};

        if (s1Mul)
            resultNext = ProdWidth'(s1Prod[WordWidth-1:0]);
        else if (s1Mfhi)
            resultNext = ProdWidth'(hiLo[ProdWidth-1:WordWidth]);
        else if (s1Mflo)
            resultNext = ProdWidth'(hiLo[WordWidth-1:0]);
        else
            resultNext = hiLoNext; // new pair
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hiLo        <= '0;
            stage2Valid <= 1'b0;
            ownsResult  <= 1'b0;
        end
        else
        begin
            hiLo        <= hiLoNext;
            stage2Valid <= s1Valid;
            ownsResult  <= s1Owns;
        end
    end

    always_ff @(posedge clk)
    begin
        hiLoResult <= resultNext;
    end

endmodule

// File: logic/exMultWriteback.sv
// count path alignment, result select and registered result and flags
module exMultWriteback
    import exMultPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    exOpIf.sink                  op,
    input  logic [ProdWidth-1:0] countOut,
    input  logic                 stage2Valid,
    input  logic                 ownsResult,
    input  logic [ProdWidth-1:0] hiLoResult,
    output logic                 resValid,
    output logic [ProdWidth-1:0] result,
    output logic [FlagWidth-1:0] flags
);

    logic [ProdWidth-1:0] countS1;
    logic [ProdWidth-1:0] countS2;
    logic [ProdWidth-1:0] selResult;
    logic [FlagWidth-1:0] selFlags;

    // follow the HI/LO pipe so both paths meet at stage 2
    always_ff @(posedge clk)
    begin
        if (op.valid)
            countS1 <= countOut;
        countS2 <= countS1;
    end

    always_comb
    begin
        selResult       = ownsResult ? hiLoResult : countS2;
        selFlags[FlagC] = selResult[WordWidth];
        selFlags[FlagZ] = selResult[WordWidth-1:0] == '0;
        selFlags[FlagO] = selResult[WordWidth];
        selFlags[FlagN] = selResult[WordWidth-1];
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            resValid <= 1'b0;
        else
            resValid <= stage2Valid;
    end

    always_ff @(posedge clk)
    begin
        result <= selResult;
        flags  <= selFlags;
    end

endmodule

// File: logic/exMultTop.sv
// execute multiply/count top level mapping plain ports onto the operation bus
module exMultTop
    import exMultPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 issueValid,
    input  logic [WordWidth-1:0] a,
    input  logic [WordWidth-1:0] b,
    input  logic                 selB,
    input  logic [5:0]           opCode,
    input  logic [5:0]           func,
    output logic                 resValid,
    output logic [ProdWidth-1:0] result,
    output logic [FlagWidth-1:0] flags
);

    logic [WordWidth-1:0] mB;
    logic [ProdWidth-1:0] countOut;
    logic                 stage2Valid;
    logic                 ownsResult;
    logic [ProdWidth-1:0] hiLoResult;

    exOpIf opBus ();

    assign opBus.valid  = issueValid;
    assign opBus.a      = a;
    assign opBus.b      = b;
    assign opBus.selB   = selB;
    assign opBus.opCode = opCode;
    assign opBus.func   = func;

    exMultCount countUnit
    (
        .op       (opBus),
        .mB       (mB),
        .countOut (countOut)
    );

    exHiLoUnit hiLoUnit
    (
        .clk         (clk),
        .arstN       (arstN),
        .op          (opBus),
        .mB          (mB),
        .stage2Valid (stage2Valid),
        .ownsResult  (ownsResult),
        .hiLoResult  (hiLoResult)
    );

    exMultWriteback writeback
    (
        .clk         (clk),
        .arstN       (arstN),
        .op          (opBus),
        .countOut    (countOut),
        .stage2Valid (stage2Valid),
        .ownsResult  (ownsResult),
        .hiLoResult  (hiLoResult),
        .resValid    (resValid),
        .result      (result),
        .flags       (flags)
    );

endmodule

// File: verif/exMultTb.sv
// testbench for exMultTop with clock, reset, HI/LO reference model, stimulus and assertions
module exMultTb
    import exMultPkg::*;
    import mipsIsaPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 arstN;
    logic                 issueValid;
    logic [WordWidth-1:0] a;
    logic [WordWidth-1:0] b;
    logic                 selB;
    logic [5:0]           opCode;
    logic [5:0]           func;
    logic                 resValid;
    logic [ProdWidth-1:0] result;
    logic [FlagWidth-1:0] flags;

    logic [ProdWidth-1:0] modelHiLo;  // {HI, LO} as the model sees it
    logic [ProdWidth-1:0] expQ[$];    // results still in flight
    logic [ProdWidth-1:0] expResult;
    logic [FlagWidth-1:0] expFlags;

    int resultErrors;
    int flagErrors;
    int timingErrors;
    int otherErrors;

    exMultTop uut
    (
        .clk        (clk),
        .arstN      (arstN),
        .issueValid (issueValid),
        .a          (a),
        .b          (b),
        .selB       (selB),
        .opCode     (opCode),
        .func       (func),
        .resValid   (resValid),
        .result     (result),
        .flags      (flags)
    );

    always #4 clk = ~clk; // 8 ns period

    // resValid rises at the second edge after issue, so it is sampled high one edge later
    property resultTwoEdgesLater;
        @(posedge clk) disable iff (!arstN) resValid == $past(issueValid, 3);
    endproperty

    assert property (resultTwoEdgesLater)
    else
    begin
        timingErrors++;
        $display("[ERROR] %0t ns resValid expected %b got %b",
                 $time, !$sampled(resValid), $sampled(resValid));
    end

    function automatic logic [ProdWidth-1:0] productOf(input logic [WordWidth-1:0] x,
                                                       input logic [WordWidth-1:0] y,
                                                       input logic             signedOp);
        logic [ProdWidth-1:0] xe;
        logic [ProdWidth-1:0] ye;
        xe = signedOp ? {{WordWidth{x[WordWidth-1]}}, x} : {{WordWidth{1'b0}}, x};
        ye = signedOp ? {{WordWidth{y[WordWidth-1]}}, y} : {{WordWidth{1'b0}}, y};
        return xe * ye; // low 64 bits are exact for both signednesses
    endfunction

    function automatic logic [ProdWidth-1:0] leadingCount(input logic [WordWidth-1:0] word,
                                                          input logic             bitValue);
        int n;
        n = 0;
        while (n < WordWidth && word[WordWidth-1-n] == bitValue)
            n++;
        return ProdWidth'(n);
    endfunction

    function automatic logic [FlagWidth-1:0] flagsOf(input logic [ProdWidth-1:0] res);
        logic [FlagWidth-1:0] f;
        f[FlagC] = res[32];
        f[FlagO] = res[32];
        f[FlagZ] = res[31:0] == 32'h0;
        f[FlagN] = res[31];
        return f;
    endfunction

    // in-order model, so updating HI/LO at issue time matches stage 2
    task automatic predict(input logic [5:0] opc, input logic [5:0] fn,
                           input logic [WordWidth-1:0] va, input logic [WordWidth-1:0] vb,
                           input logic sel);
        logic [WordWidth-1:0] vm;
        logic [ProdWidth-1:0] res;
        vm  = sel ? vb : 32'd1;
        res = {32'h0, va}; // passthrough unless decoded below
        if (opc == OpSpecial)
        begin
            case (fn)
                FuncMult:  modelHiLo = productOf(va, vm, 1'b1);
                FuncMultu: modelHiLo = productOf(va, vm, 1'b0);
                FuncMthi:  modelHiLo[63:32] = va;
                FuncMtlo:  modelHiLo[31:0] = va;
                default:   ;
            endcase
            case (fn)
                FuncMult, FuncMultu, FuncMthi, FuncMtlo: res = modelHiLo;
                FuncMfhi: res = {32'h0, modelHiLo[63:32]};
                FuncMflo: res = {32'h0, modelHiLo[31:0]};
                default:  ;
            endcase
        end
        else if (opc == OpSpecial2)
        begin
            case (fn)
                FuncMul:   res = {32'h0, va * vm}; // low word, same for both signednesses
                FuncMadd:  modelHiLo = modelHiLo + productOf(va, vm, 1'b1);
                FuncMaddu: modelHiLo = modelHiLo + productOf(va, vm, 1'b0);
                FuncMsub:  modelHiLo = modelHiLo - productOf(va, vm, 1'b1);
                FuncMsubu: modelHiLo = modelHiLo - productOf(va, vm, 1'b0);
                FuncClz:   res = leadingCount(va, 1'b0);
                FuncClo:   res = leadingCount(va, 1'b1);
                default:   ;
            endcase
            if (fn inside {FuncMadd, FuncMaddu, FuncMsub, FuncMsubu})
                res = modelHiLo;
        end
        expQ.push_back(res);
    endtask

    task automatic issueOp(input logic [5:0] opc, input logic [5:0] fn,
                           input logic [WordWidth-1:0] va, input logic [WordWidth-1:0] vb,
                           input logic sel);
        @(posedge clk);
        #1;
        issueValid = 1'b1;
        opCode     = opc;
        func       = fn;
        a          = va;
        b          = vb;
        selB       = sel;
        predict(opc, fn, va, vb, sel);
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        issueValid = 1'b0;
        a          = $urandom(); // noise on unused lanes
    endtask

    task automatic drainResults(input int limit);
        int cycles;
        idle();
        cycles = 0;
        while (expQ.size() != 0 && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (expQ.size() != 0)
        begin
            $display("timeout: %0d results still outstanding after %0d cycles",
                     expQ.size(), limit);
            $display("Regression failed");
            $finish;
        end
    endtask

    // outputs settle at the rising edge, compare mid-cycle
    always @(negedge clk)
    begin
        if (arstN && resValid)
        begin
            if (expQ.size() == 0)
            begin
                otherErrors++;
                $display("%0t ns: result presented with no operation outstanding", $time);
            end
            else
            begin
                expResult = expQ.pop_front();
                expFlags  = flagsOf(expResult);
                assert (result === expResult)
                else
                begin
                    resultErrors++;
                    $display("[ERROR] %0t ns result expected %h got %h",
                             $time, expResult, result);
                end
                assert (flags === expFlags)
                else
                begin
                    flagErrors++;
                    $display("[ERROR] %0t ns flags expected %b got %b", $time, expFlags, flags);
                end
            end
        end
    end

    task automatic testCounts();
        logic [WordWidth-1:0] v;
        issueOp(OpSpecial2, FuncClz, 32'h0, 32'h0, 1'b1);
        issueOp(OpSpecial2, FuncClo, 32'h0, 32'h0, 1'b1);
        issueOp(OpSpecial2, FuncClz, 32'hffff_ffff, 32'h0, 1'b1);
        issueOp(OpSpecial2, FuncClo, 32'hffff_ffff, 32'h0, 1'b1);
        for (int i = 0; i < WordWidth; i++)
        begin
            v = 32'h1 << i;
            issueOp(OpSpecial2, FuncClz, v, 32'h0, 1'b1);  // one-hot
            issueOp(OpSpecial2, FuncClo, ~v, 32'h0, 1'b1); // one-cold
        end
        for (int i = 0; i < 24; i++)
        begin
            v = $urandom() >> ($urandom() % 32);
            issueOp(OpSpecial2, i[0] ? FuncClo : FuncClz, i[0] ? ~v : v, 32'h0, 1'b1);
        end
        drainResults(10);
    endtask

    task automatic testMultiplies();
        logic [WordWidth-1:0] edges[5];
        edges = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0, 32'h1};
        foreach (edges[i])
        begin
            foreach (edges[j])
            begin
                issueOp(OpSpecial, FuncMult, edges[i], edges[j], 1'b1);
                issueOp(OpSpecial, FuncMultu, edges[i], edges[j], 1'b1);
            end
        end
        for (int i = 0; i < 20; i++)
            issueOp(OpSpecial, i[0] ? FuncMultu : FuncMult, $urandom(), $urandom(), 1'b1);
        // MUL must leave the pair from the MULT before it
        issueOp(OpSpecial2, FuncMul, $urandom(), $urandom(), 1'b1);
        issueOp(OpSpecial2, FuncMul, 32'hffff_fffe, 32'h7fff_ffff, 1'b1);
        issueOp(OpSpecial, FuncMfhi, 32'h0, 32'h0, 1'b1);
        issueOp(OpSpecial, FuncMflo, 32'h0, 32'h0, 1'b1);
        for (int i = 0; i < 6; i++)
            issueOp(OpSpecial, FuncMult, $urandom(), $urandom(), 1'b0); // B forced to 1
        drainResults(10);
    endtask

    task automatic testAccumulate();
        logic [5:0] accFuncs[4];
        accFuncs = '{FuncMadd, FuncMaddu, FuncMsub, FuncMsubu};
        issueOp(OpSpecial, FuncMthi, $urandom(), 32'h0, 1'b1);
        issueOp(OpSpecial, FuncMtlo, $urandom(), 32'h0, 1'b1);
        for (int i = 0; i < 32; i++)
            issueOp(OpSpecial2, accFuncs[$urandom() % 4], $urandom(), $urandom(), 1'b1);
        issueOp(OpSpecial, FuncMfhi, 32'h0, 32'h0, 1'b1);
        issueOp(OpSpecial, FuncMflo, 32'h0, 32'h0, 1'b1);
        drainResults(10);
    endtask

    task automatic testMoves();
        for (int i = 0; i < 4; i++)
        begin
            issueOp(OpSpecial, FuncMthi, $urandom(), 32'h0, 1'b1);
            issueOp(OpSpecial, FuncMtlo, $urandom(), 32'h0, 1'b1);
            issueOp(OpSpecial, FuncMfhi, $urandom(), 32'h0, 1'b1);
            issueOp(OpSpecial, FuncMflo, $urandom(), 32'h0, 1'b1);
        end
        issueOp(OpSpecial, 6'b100001, $urandom(), $urandom(), 1'b1);  // ADDU
        issueOp(6'b001000, FuncMult, 32'h8000_0000, $urandom(), 1'b1); // ADDI
        issueOp(OpSpecial2, 6'b111111, 32'h0, $urandom(), 1'b1);
        issueOp(6'b100011, 6'b000000, $urandom(), $urandom(), 1'b0);
        drainResults(10);
    endtask

    initial
    begin
        void'($urandom(32'h5e86_61bb));
        clk          = 1'b0;
        arstN        = 1'b0;
        issueValid   = 1'b0;
        a            = '0;
        b            = '0;
        selB         = 1'b1;
        opCode       = '0;
        func         = '0;
        modelHiLo    = '0;
        resultErrors = 0;
        flagErrors   = 0;
        timingErrors = 0;
        otherErrors  = 0;
        repeat (4) @(posedge clk);
        #1;
        arstN = 1'b1;
        assert (resValid === 1'b0)
        else
        begin
            resultErrors++;
            $display("[ERROR] %0t ns resValid expected 0 got %b", $time, resValid);
        end
        issueOp(OpSpecial, FuncMfhi, 32'h0, 32'h0, 1'b1);
        idle();
        issueOp(OpSpecial, FuncMflo, 32'h0, 32'h0, 1'b1);
        drainResults(10);
        testCounts();
        testMultiplies();
        testAccumulate();
        testMoves();
        repeat (3) @(posedge clk);
        $display("errors: result %0d, flags %0d, timing %0d, other %0d",
                 resultErrors, flagErrors, timingErrors, otherErrors);
        if (resultErrors + flagErrors + timingErrors + otherErrors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: compile.f
logic/mipsIsaPkg.sv
logic/exMultPkg.sv
logic/exOpIf.sv
logic/exMultCount.sv
logic/exHiLoUnit.sv
logic/exMultWriteback.sv
logic/exMultTop.sv
verif/exMultTb.sv

// File: Bender.yml
package:
  name: ex_mult

sources:
  - logic/mipsIsaPkg.sv
  - logic/exMultPkg.sv
  - logic/exOpIf.sv
  - logic/exMultCount.sv
  - logic/exHiLoUnit.sv
  - logic/exMultWriteback.sv
  - logic/exMultTop.sv
  - target: test
    files:
      - verif/exMultTb.sv
